/* design/luma_cost_defs.svh */
// Luma mode decision: shared width and size constants

`ifndef LUMA_COST_DEFS_SVH
`define LUMA_COST_DEFS_SVH

// ----------------------------------------------------------------------
// Coefficient block geometry
// ----------------------------------------------------------------------

// Bits per signed coefficient
`define COEF_WIDTH 16

// Rows per block, coefficients per row
`define BLOCK_SIZE 16

// Candidate intra 16x16 modes
`define NUM_MODES 4

// Accumulated cost, wraps modulo 2^32
`define COST_WIDTH 32

`endif

/* design/coef_pkg.sv */
// Coefficient package: scalar, row and block types of the residual data

`include "luma_cost_defs.svh"

package coef_pkg;

    // ------------------------------------------------------------------
    // Scalar and row types
    // ------------------------------------------------------------------

    // One signed transform coefficient
    typedef logic signed [`COEF_WIDTH-1:0] coef_t;

    // One row of AC coefficients, element 0 in the low bits
    typedef coef_t [`BLOCK_SIZE-1:0] coef_row_t;

    // Row number inside a block
    typedef logic [$clog2(`BLOCK_SIZE)-1:0] row_idx_t;

    // ------------------------------------------------------------------
    // Block type
    // ------------------------------------------------------------------

    // Full residual block of one mode
    // dc[r] is the DC term that belongs to row r
    typedef struct packed {
        coef_row_t [`BLOCK_SIZE-1:0] ac;
        coef_row_t                   dc;
    } coef_block_t;

endpackage

/* design/mode_pkg.sv */
// Mode package: cost, mode and controller types of the mode search

`include "luma_cost_defs.svh"

package mode_pkg;

    // ------------------------------------------------------------------
    // Cost and mode numbers
    // ------------------------------------------------------------------

    // Sum of squares, unsigned and wrapping
    typedef logic [`COST_WIDTH-1:0] cost_t;

    // Candidate mode number
    typedef logic [$clog2(`NUM_MODES)-1:0] mode_idx_t;

    // Intra 16x16 luma prediction modes, in search order
    typedef enum mode_idx_t {
        vertical   = 0,
        horizontal = 1,
        dc         = 2,
        plane      = 3
    } intra16_mode_e;

    // Controller states
    typedef enum logic [1:0] {
        idle,
        load,
        run,
        compare
    } search_state_e;

    // Decision outcome
    typedef struct packed {
        mode_idx_t best_mode;
        cost_t     best_cost;
    } mode_result_t;

endpackage

/* design/mode_search_fsm.sv */
// Mode search controller: walks the four modes through load, run and compare

`include "luma_cost_defs.svh"

module mode_search_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                last_row,
    output logic                count_en,
    output logic                acc_clear,
    output logic                acc_en,
    output logic                update,
    output mode_pkg::mode_idx_t mode_idx,
    output logic                busy,
    output logic                done
);

    import mode_pkg::*;

    search_state_e state;
    search_state_e state_nxt;
    logic          last_mode;

    // Plane is searched last
    assign last_mode = (mode_idx == mode_idx_t'(plane));

    // ------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (start) begin
                    state_nxt = load;
                end
            end
            load: begin
                state_nxt = run;
            end
            run: begin
                // Counter flags row 15
                if (last_row) begin
                    state_nxt = compare;
                end
            end
            compare: begin
                state_nxt = last_mode ? idle : load;
            end
            default: begin
                state_nxt = idle;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // State, mode number and done pulse
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= idle;
            mode_idx <= '0;
            done     <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= (state == compare) && last_mode;
            if ((state == idle) && start) begin
                mode_idx <= '0;
            end else if ((state == compare) && !last_mode) begin
                mode_idx <= mode_idx + mode_idx_t'(1);
            end
        end
    end

    // Strobes decoded from the state
    assign acc_clear = (state == load);
    assign acc_en    = (state == run);
    assign count_en  = (state == run);
    assign update    = (state == compare);
    assign busy      = (state != idle);

endmodule

/* design/row_counter.sv */
// Row counter: steps through the sixteen coefficient rows of a block

`include "luma_cost_defs.svh"

module row_counter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               count_en,
    output coef_pkg::row_idx_t row,
    output logic               last_row
);

    import coef_pkg::*;

    localparam row_idx_t LAST = row_idx_t'(`BLOCK_SIZE - 1);

    // Wraps back to row 0 after the last row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row <= '0;
        end else if (count_en) begin
            if (row == LAST) begin
                row <= '0;
            end else begin
                row <= row + row_idx_t'(1);
            end
        end
    end

    // Final row of the current pass
    assign last_row = count_en && (row == LAST);

endmodule

/* design/coef_cost_accum.sv */
// Cost accumulator: adds the squares of one row and its DC term per cycle

`include "luma_cost_defs.svh"

module coef_cost_accum (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  acc_clear,
    input  logic                  acc_en,
    input  coef_pkg::row_idx_t    row,
    input  coef_pkg::coef_block_t coef,
    output mode_pkg::cost_t       cost
);

    import coef_pkg::*;
    import mode_pkg::*;

    coef_row_t ac_row;
    coef_t     dc_term;
    cost_t     row_sum;

    // Signed square, never negative
    function automatic cost_t square(input coef_t c);
        logic signed [2*`COEF_WIDTH-1:0] prod;
        prod = c * c;
        return cost_t'(prod);
    endfunction

    // ------------------------------------------------------------------
    // Row select
    // ------------------------------------------------------------------

    assign ac_row  = coef.ac[row];
    assign dc_term = coef.dc[row];

    // ------------------------------------------------------------------
    // Seventeen squares of the selected row
    // ------------------------------------------------------------------

    always_comb begin
        row_sum = square(dc_term);
        for (int i = 0; i < `BLOCK_SIZE; i++) begin
            row_sum = row_sum + square(ac_row[i]);
        end
    end

    // Running cost, wraps modulo 2^32
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cost <= '0;
        end else if (acc_clear) begin
            cost <= '0;
        end else if (acc_en) begin
            cost <= cost + row_sum;
        end
    end

endmodule

/* design/best_mode_tracker.sv */
// Best mode tracker: keeps the lowest cost seen in a search and its mode

`include "luma_cost_defs.svh"

module best_mode_tracker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   update,
    input  mode_pkg::mode_idx_t    mode_idx,
    input  mode_pkg::cost_t        cost,
    output mode_pkg::mode_result_t result
);

    import mode_pkg::*;

    logic first_mode;
    logic lower;
    logic take;

    // The first mode always seeds the search
    assign first_mode = (mode_idx == mode_idx_t'(vertical));

    // Strict compare, so a tie keeps the earlier mode
    assign lower = (cost < result.best_cost);

    assign take = update && (first_mode || lower);

    // ------------------------------------------------------------------
    // Result register
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (take) begin
            result.best_mode <= mode_idx;
            result.best_cost <= cost;
        end
    end

endmodule

/* design/luma_mode_decision.sv */
// Intra 16x16 luma mode decision: picks the mode with the lowest residual cost

`include "luma_cost_defs.svh"

module luma_mode_decision (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  coef_pkg::coef_block_t  coef,
    output mode_pkg::mode_idx_t    mode_idx,
    output logic                   busy,
    output logic                   done,
    output mode_pkg::mode_result_t result
);

    import coef_pkg::*;
    import mode_pkg::*;

    logic     count_en;
    logic     acc_clear;
    logic     acc_en;
    logic     update;
    logic     last_row;
    row_idx_t row;
    cost_t    cost;

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------

    mode_search_fsm i_mode_search_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .last_row  (last_row),
        .count_en  (count_en),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .update    (update),
        .mode_idx  (mode_idx),
        .busy      (busy),
        .done      (done)
    );

    row_counter i_row_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .count_en (count_en),
        .row      (row),
        .last_row (last_row)
    );

    // ------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------

    coef_cost_accum i_coef_cost_accum (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .row       (row),
        .coef      (coef),
        .cost      (cost)
    );

    best_mode_tracker i_best_mode_tracker (
        .clk      (clk),
        .rst_n    (rst_n),
        .update   (update),
        .mode_idx (mode_idx),
        .cost     (cost),
        .result   (result)
    );

endmodule

/* verif/luma_mode_decision_chk.sv */
// Control timing checker for the luma mode decision top level

`include "luma_cost_defs.svh"

module luma_mode_decision_chk (
    input logic                clk,
    input logic                rst_n,
    input logic                start,
    input logic                busy,
    input logic                done,
    input mode_pkg::mode_idx_t mode_idx
);

    timeunit 1ns;
    timeprecision 1ps;

    import mode_pkg::*;

    logic accepted;

    // Start seen while the controller is idle
    assign accepted = start && !busy;

    // ------------------------------------------------------------------
    // Done pulse
    // ------------------------------------------------------------------

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Done is set at edge 72 and first sampled high one edge later
    done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $past(accepted, 73))
        else $error("done did not follow an accepted start by 72 cycles");

    // ------------------------------------------------------------------
    // Busy level and mode order
    // ------------------------------------------------------------------

    busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        accepted |=> busy)
        else $error("busy did not rise after an accepted start");

    busy_ends_with_done: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> done)
        else $error("busy fell without a done pulse");

    // Mode number only steps up by one inside a search
    mode_steps_up: assert property (@(posedge clk) disable iff (!rst_n)
        (busy && $past(busy) && (mode_idx != $past(mode_idx))) |->
            (($past(mode_idx) != mode_idx_t'(plane)) &&
             (mode_idx == $past(mode_idx) + mode_idx_t'(1))))
        else $error("mode_idx did not step up by one during a search");

endmodule

/* verif/luma_mode_decision_tb.sv */
// Luma mode decision testbench with random coefficient blocks and a cost model

`include "luma_cost_defs.svh"

module luma_mode_decision_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import coef_pkg::*;
    import mode_pkg::*;

    localparam int NUM_DEC    = 20;
    localparam int MODE_LEN   = 18;
    localparam int DONE_CYCLE = 72;

    logic         clk;
    logic         rst_n;
    logic         start;
    coef_block_t  coef;
    mode_idx_t    mode_idx;
    logic         busy;
    logic         done;
    mode_result_t result;

    coef_block_t  blk [`NUM_MODES];
    cost_t        exp_cost;
    mode_idx_t    exp_mode;
    integer       seed;
    int           errors;
    int           checks;

    always #50 clk = ~clk;

    luma_mode_decision i_luma_mode_decision (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .coef     (coef),
        .mode_idx (mode_idx),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    bind luma_mode_decision luma_mode_decision_chk i_luma_mode_decision_chk (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .busy     (busy),
        .done     (done),
        .mode_idx (mode_idx)
    );

    // ------------------------------------------------------------------
    // Stimulus and reference model
    // ------------------------------------------------------------------

    function automatic string kind_name(input int kind);
        case (kind)
            1:       return "winner";
            2:       return "tie";
            3:       return "wrap";
            4:       return "busy_start";
            default: return "random";
        endcase
    endfunction

    // Small values unless full range is asked for
    function automatic coef_t random_coef(input bit full);
        int v;
        v = $random(seed);
        if (!full) begin
            v = v % 256;
        end
        return coef_t'(v);
    endfunction

    // Wrapped sum of squares over all AC and DC terms
    function automatic cost_t block_cost(input coef_block_t b);
        coef_t  v;
        longint sq;
        cost_t  sum;
        sum = '0;
        for (int r = 0; r < `BLOCK_SIZE; r++) begin
            v   = b.dc[r];
            sq  = longint'(v) * longint'(v);
            sum = sum + cost_t'(sq);
            for (int c = 0; c < `BLOCK_SIZE; c++) begin
                v   = b.ac[r][c];
                sq  = longint'(v) * longint'(v);
                sum = sum + cost_t'(sq);
            end
        end
        return sum;
    endfunction

    task automatic make_blocks(input int kind);
        mode_idx_t w;
        coef_t     tmp;
        for (int m = 0; m < `NUM_MODES; m++) begin
            for (int r = 0; r < `BLOCK_SIZE; r++) begin
                blk[m].dc[r] = random_coef(kind == 3);
                for (int c = 0; c < `BLOCK_SIZE; c++) begin
                    blk[m].ac[r][c] = random_coef(kind == 3);
                end
            end
        end
        w = mode_idx_t'($random(seed));
        // Tie pairs a low mode with the mode two above it
        if (kind == 2) begin
            w = mode_idx_t'(w & mode_idx_t'(1));
        end
        if (kind == 1 || kind == 2) begin
            for (int r = 0; r < `BLOCK_SIZE; r++) begin
                tmp = blk[w].dc[r];
                blk[w].dc[r] = tmp >>> 3;
                for (int c = 0; c < `BLOCK_SIZE; c++) begin
                    tmp = blk[w].ac[r][c];
                    blk[w].ac[r][c] = tmp >>> 3;
                end
            end
        end
        if (kind == 2) begin
            blk[w + mode_idx_t'(2)] = blk[w];
        end
    endtask

    // Lowest cost wins and a tie keeps the earlier mode
    task automatic compute_expected();
        cost_t c;
        exp_mode = '0;
        exp_cost = block_cost(blk[0]);
        for (int m = 1; m < `NUM_MODES; m++) begin
            c = block_cost(blk[m]);
            if (c < exp_cost) begin
                exp_cost = c;
                exp_mode = mode_idx_t'(m);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // One decision from start to done
    // ------------------------------------------------------------------

    task automatic run_decision(input int num, input int kind);
        string name;
        int    n;
        name = kind_name(kind);
        make_blocks(kind);
        compute_expected();
        @(posedge clk);
        #5;
        start = 1'b1;
        coef  = blk[0];
        @(posedge clk);
        #5;
        start = 1'b0;
        n     = 0;
        while (!done) begin
            coef = blk[mode_idx];
            checks++;
            if (mode_idx != mode_idx_t'(n / MODE_LEN)) begin
                errors++;
                $display("[FAIL] %s %0d: cycle %0d mode_idx expected %0d, actual %0d",
                         name, num, n, n / MODE_LEN, mode_idx);
            end
            if (!busy) begin
                errors++;
                $display("%s %0d: busy low during the search at cycle %0d", name, num, n);
            end
            // Extra start in the middle of the search
            start = (kind == 4) && (n == 30);
            @(posedge clk);
            #5;
            n++;
        end
        checks++;
        if (n != DONE_CYCLE) begin
            errors++;
            $display("[FAIL] %s %0d: done cycle expected %0d, actual %0d",
                     name, num, DONE_CYCLE, n);
        end
        if (busy) begin
            errors++;
            $display("%s %0d: busy still high in the done cycle", name, num);
        end
        if (result.best_mode != exp_mode) begin
            errors++;
            $display("[FAIL] %s %0d: best_mode expected %0d, actual %0d",
                     name, num, exp_mode, result.best_mode);
        end
        if (result.best_cost != exp_cost) begin
            errors++;
            $display("[FAIL] %s %0d: best_cost expected %08h, actual %08h",
                     name, num, exp_cost, result.best_cost);
        end
        repeat (2) begin
            @(posedge clk);
            #5;
            if (done || busy) begin
                errors++;
                $display("%s %0d: controller active again after done", name, num);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        start  = 1'b0;
        coef   = '0;
        seed   = 32'hc664ef54;
        errors = 0;
        checks = 0;
        repeat (16) @(posedge clk);
        #5;
        rst_n = 1'b1;
        for (int d = 0; d < NUM_DEC; d++) begin
            run_decision(d, d % 5);
        end
        $display("Decisions: %0d, checks: %0d, errors: %0d", NUM_DEC, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (NUM_DEC * 80 + 100) @(posedge clk);
        $display("Watchdog expired before all decisions finished");
        $display("** FAIL **");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+design
design/coef_pkg.sv
design/mode_pkg.sv
design/mode_search_fsm.sv
design/row_counter.sv
design/coef_cost_accum.sv
design/best_mode_tracker.sv
design/luma_mode_decision.sv
verif/luma_mode_decision_chk.sv
verif/luma_mode_decision_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the luma mode decision testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
EXE=sim_luma_mode_decision

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module luma_mode_decision_tb \
    --Mdir "$BUILD_DIR" -o "$EXE"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "\*\* FAIL \*\*" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
exit 0
